//--- hw/csr_pkg.sv
package csr_pkg;

    localparam int XLEN    = 32;
    localparam int NUM_IRQ = 8;

    typedef logic [XLEN-1:0]    xlen_t;
    typedef logic [XLEN-1:0]    addr_t;
    typedef logic [11:0]        csr_addr_t;
    typedef logic [NUM_IRQ-1:0] irq_vec_t;
    typedef logic [3:0]         wb_adr_t;

    // machine CSR numbers.
    localparam csr_addr_t CSR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_MIE       = 12'h304;
    localparam csr_addr_t CSR_MTVEC     = 12'h305;
    localparam csr_addr_t CSR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_MIP       = 12'h344;
    localparam csr_addr_t CSR_MCYCLE    = 12'hb00;
    localparam csr_addr_t CSR_MINSTRET  = 12'hb02;
    localparam csr_addr_t CSR_MCYCLEH   = 12'hb80;
    localparam csr_addr_t CSR_MINSTRETH = 12'hb82;

    localparam addr_t MTVEC_RESET = 32'h0001_0000;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MEIP_BIT         = 11;

    // instruction encodings.
    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;
    localparam xlen_t      INSTR_MRET    = 32'h3020_0073;
    localparam xlen_t      INSTR_WFI     = 32'h1050_0073;

    // interrupt controller register offsets.
    localparam wb_adr_t IRQ_PENDING = 4'h0;
    localparam wb_adr_t IRQ_ENABLE  = 4'h4;
    localparam wb_adr_t IRQ_RAW     = 4'h8;

    typedef enum logic [2:0] {
        NONE,
        WRITE,
        SET,
        CLEAR,
        MRET,
        WFI
    } csr_op_e;

    typedef struct packed {
        logic      valid;
        csr_op_e   op;
        csr_addr_t addr;
        xlen_t     operand;
        logic      operand_nz;
        addr_t     pc;
    } csr_req_t;

    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        xlen_t   dat;
    } wb_req_t;

    typedef struct packed {
        xlen_t dat;
        logic  ack;
    } wb_rsp_t;

endpackage

//--- hw/csr_decode.sv
`timescale 1ns/1ps

module csr_decode (
    input  logic              instr_valid_i,
    input  csr_pkg::xlen_t    instr_i,
    input  csr_pkg::addr_t    pc_i,
    input  csr_pkg::xlen_t    rs1_data_i,
    output csr_pkg::csr_req_t req_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] src_field;
    logic       is_system;
    csr_pkg::xlen_t uimm;

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign src_field = instr_i[19:15];
    assign is_system = (opcode == csr_pkg::OPCODE_SYSTEM);

    // zero-extended immediate source.
    assign uimm = {{(csr_pkg::XLEN-5){1'b0}}, src_field};

    always_comb begin
        req_o.valid      = instr_valid_i;
        req_o.addr       = instr_i[31:20];
        req_o.pc         = pc_i;
        req_o.operand_nz = |src_field;
        // funct3[2] picks the immediate form.
        req_o.operand    = funct3[2] ? uimm : rs1_data_i;
        req_o.op         = csr_pkg::NONE;

        if (is_system) begin
            case (funct3[1:0])
                2'b01: begin
                    req_o.op = csr_pkg::WRITE;
                end
                2'b10: begin
                    req_o.op = csr_pkg::SET;
                end
                2'b11: begin
                    req_o.op = csr_pkg::CLEAR;
                end
                default: begin
                    // only the fixed privileged encodings.
                    if (instr_i == csr_pkg::INSTR_MRET) begin
                        req_o.op = csr_pkg::MRET;
                    end
                    else if (instr_i == csr_pkg::INSTR_WFI) begin
                        req_o.op = csr_pkg::WFI;
                    end
                    else begin
                        req_o.op = csr_pkg::NONE;
                    end
                end
            endcase
        end
    end

endmodule

//--- hw/csr_file.sv
`timescale 1ns/1ps

module csr_file (
    input  logic              clk,
    input  logic              rst,
    input  csr_pkg::csr_req_t req_i,
    input  logic              meip_i,
    output csr_pkg::xlen_t    rd_data_o,
    output logic              trap_o,
    output csr_pkg::addr_t    trap_pc_o,
    output logic              mret_o,
    output csr_pkg::addr_t    ret_pc_o,
    output logic              stall_o
);

    logic                               mstatus_mie_q;
    logic                               mstatus_mpie_q;
    logic                               mie_meie_q;
    logic [csr_pkg::XLEN-1:2]           mtvec_q;
    logic [csr_pkg::XLEN-1:2]           mepc_q;
    logic [2*csr_pkg::XLEN-1:0]         mcycle_q;
    logic [2*csr_pkg::XLEN-1:0]         minstret_q;
    logic                               stall_q;

    logic           req_ok;
    logic           csr_op;
    logic           wfi_go;
    logic           csr_we;
    csr_pkg::xlen_t rdata;
    csr_pkg::xlen_t wdata;
    csr_pkg::addr_t wfi_pc;

    // requests issued during a stall are dropped.
    assign req_ok = req_i.valid && !stall_q;

    assign trap_o = req_ok && meip_i && mie_meie_q && mstatus_mie_q;
    assign mret_o = req_ok && !trap_o && (req_i.op == csr_pkg::MRET);
    assign wfi_go = req_ok && !trap_o && (req_i.op == csr_pkg::WFI);

    assign csr_op = req_ok && !trap_o &&
                    ((req_i.op == csr_pkg::WRITE) ||
                     (req_i.op == csr_pkg::SET) ||
                     (req_i.op == csr_pkg::CLEAR));

    // set and clear with x0 or a zero uimm only read.
    assign csr_we = csr_op && ((req_i.op == csr_pkg::WRITE) || req_i.operand_nz);

    assign trap_pc_o = {mtvec_q, 2'b00};
    assign ret_pc_o  = {mepc_q, 2'b00};
    assign stall_o   = stall_q;
    assign wfi_pc    = req_i.pc + csr_pkg::addr_t'(4);

    always_comb begin
        rdata = '0;
        case (req_i.addr)
            csr_pkg::CSR_MSTATUS: begin
                rdata[csr_pkg::MSTATUS_MIE_BIT]  = mstatus_mie_q;
                rdata[csr_pkg::MSTATUS_MPIE_BIT] = mstatus_mpie_q;
            end
            csr_pkg::CSR_MIE: begin
                rdata[csr_pkg::MEIP_BIT] = mie_meie_q;
            end
            csr_pkg::CSR_MTVEC: begin
                rdata = {mtvec_q, 2'b00};
            end
            csr_pkg::CSR_MEPC: begin
                rdata = {mepc_q, 2'b00};
            end
            csr_pkg::CSR_MIP: begin
                rdata[csr_pkg::MEIP_BIT] = meip_i;
            end
            csr_pkg::CSR_MCYCLE: begin
                rdata = mcycle_q[csr_pkg::XLEN-1:0];
            end
            csr_pkg::CSR_MCYCLEH: begin
                rdata = mcycle_q[2*csr_pkg::XLEN-1:csr_pkg::XLEN];
            end
            csr_pkg::CSR_MINSTRET: begin
                rdata = minstret_q[csr_pkg::XLEN-1:0];
            end
            csr_pkg::CSR_MINSTRETH: begin
                rdata = minstret_q[2*csr_pkg::XLEN-1:csr_pkg::XLEN];
            end
            default: begin
                rdata = '0;
            end
        endcase
    end

    // old value, zero when the request traps.
    assign rd_data_o = csr_op ? rdata : '0;

    always_comb begin
        case (req_i.op)
            csr_pkg::SET:   wdata = rdata | req_i.operand;
            csr_pkg::CLEAR: wdata = rdata & ~req_i.operand;
            default:        wdata = req_i.operand;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
            mie_meie_q     <= 1'b0;
            mtvec_q        <= csr_pkg::MTVEC_RESET[csr_pkg::XLEN-1:2];
            mepc_q         <= '0;
        end
        else if (trap_o) begin
            mepc_q         <= req_i.pc[csr_pkg::XLEN-1:2];
            mstatus_mpie_q <= mstatus_mie_q;
            mstatus_mie_q  <= 1'b0;
        end
        else if (wfi_go) begin
            mepc_q <= wfi_pc[csr_pkg::XLEN-1:2];
        end
        else if (mret_o) begin
            mstatus_mie_q  <= mstatus_mpie_q;
            mstatus_mpie_q <= 1'b1;
        end
        else if (csr_we) begin
            case (req_i.addr)
                csr_pkg::CSR_MSTATUS: begin
                    mstatus_mie_q  <= wdata[csr_pkg::MSTATUS_MIE_BIT];
                    mstatus_mpie_q <= wdata[csr_pkg::MSTATUS_MPIE_BIT];
                end
                csr_pkg::CSR_MIE: begin
                    mie_meie_q <= wdata[csr_pkg::MEIP_BIT];
                end
                csr_pkg::CSR_MTVEC: begin
                    mtvec_q <= wdata[csr_pkg::XLEN-1:2];
                end
                csr_pkg::CSR_MEPC: begin
                    mepc_q <= wdata[csr_pkg::XLEN-1:2];
                end
                default: begin
                    // counters and mip ignore writes.
                end
            endcase
        end
    end

    // wfi sleeps until meip, whatever the enables say.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stall_q <= 1'b0;
        end
        else if (wfi_go) begin
            stall_q <= !meip_i;
        end
        else if (stall_q && meip_i) begin
            stall_q <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end
        else begin
            mcycle_q <= mcycle_q + 1'b1;
            if (req_ok && !trap_o) begin
                minstret_q <= minstret_q + 1'b1;
            end
        end
    end

    trap_mret_excl: assert property (@(posedge clk) disable iff (rst)
        !(trap_o && mret_o))
    else $error("trap and mret raised together");

    no_issue_in_stall: assert property (@(posedge clk) disable iff (rst)
        stall_o |-> !req_i.valid)
    else $error("instruction issued while stalled");

endmodule

//--- hw/ext_irq_ctrl.sv
`timescale 1ns/1ps

module ext_irq_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  csr_pkg::irq_vec_t irq_i,
    input  csr_pkg::wb_req_t  wb_i,
    output csr_pkg::wb_rsp_t  wb_o,
    output logic              meip_o
);

    csr_pkg::irq_vec_t irq_q;
    csr_pkg::irq_vec_t pending_q;
    csr_pkg::irq_vec_t enable_q;
    csr_pkg::irq_vec_t rise;
    csr_pkg::irq_vec_t clr_mask;
    csr_pkg::xlen_t    rdat_q;
    csr_pkg::xlen_t    rdat;
    logic              ack_q;
    logic              meip_q;
    logic              access;
    logic              wr_pending;
    logic              wr_enable;

    // one access per strobe, taken while ack is low.
    assign access     = wb_i.cyc && wb_i.stb && !ack_q;
    assign wr_pending = access && wb_i.we && (wb_i.adr == csr_pkg::IRQ_PENDING);
    assign wr_enable  = access && wb_i.we && (wb_i.adr == csr_pkg::IRQ_ENABLE);

    assign rise     = irq_i & ~irq_q;
    assign clr_mask = wr_pending ? wb_i.dat[csr_pkg::NUM_IRQ-1:0] : '0;

    always_comb begin
        case (wb_i.adr)
            csr_pkg::IRQ_PENDING: rdat = csr_pkg::xlen_t'(pending_q);
            csr_pkg::IRQ_ENABLE:  rdat = csr_pkg::xlen_t'(enable_q);
            csr_pkg::IRQ_RAW:     rdat = csr_pkg::xlen_t'(irq_i);
            default:              rdat = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irq_q     <= '0;
            pending_q <= '0;
            enable_q  <= '0;
            ack_q     <= 1'b0;
            meip_q    <= 1'b0;
        end
        else begin
            irq_q <= irq_i;
            // a fresh edge beats a clear in the same cycle.
            pending_q <= (pending_q & ~clr_mask) | rise;
            if (wr_enable) begin
                enable_q <= wb_i.dat[csr_pkg::NUM_IRQ-1:0];
            end
            ack_q  <= access;
            meip_q <= |(pending_q & enable_q);
        end
    end

    // read data, sampled with the access.
    always_ff @(posedge clk) begin
        if (access && !wb_i.we) begin
            rdat_q <= rdat;
        end
    end

    assign wb_o.ack = ack_q;
    assign wb_o.dat = rdat_q;
    assign meip_o   = meip_q;

    single_ack: assert property (@(posedge clk) disable iff (rst)
        (wb_o.ack && wb_i.stb) ##1 wb_i.stb |-> !wb_o.ack)
    else $error("wishbone ack held for two cycles");

endmodule

//--- hw/csr_subsys.sv
`timescale 1ns/1ps

module csr_subsys (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid_i,
    input  csr_pkg::xlen_t    instr_i,
    input  csr_pkg::addr_t    pc_i,
    input  csr_pkg::xlen_t    rs1_data_i,
    input  csr_pkg::irq_vec_t irq_i,
    input  csr_pkg::wb_req_t  wb_i,
    output csr_pkg::wb_rsp_t  wb_o,
    output csr_pkg::xlen_t    rd_data_o,
    output logic              trap_o,
    output csr_pkg::addr_t    trap_pc_o,
    output logic              mret_o,
    output csr_pkg::addr_t    ret_pc_o,
    output logic              stall_o
);

    csr_pkg::csr_req_t req;
    logic              meip;

    csr_decode csr_decode_i (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .rs1_data_i    (rs1_data_i),
        .req_o         (req)
    );

    csr_file csr_file_i (
        .clk       (clk),
        .rst       (rst),
        .req_i     (req),
        .meip_i    (meip),
        .rd_data_o (rd_data_o),
        .trap_o    (trap_o),
        .trap_pc_o (trap_pc_o),
        .mret_o    (mret_o),
        .ret_pc_o  (ret_pc_o),
        .stall_o   (stall_o)
    );

    ext_irq_ctrl ext_irq_ctrl_i (
        .clk    (clk),
        .rst    (rst),
        .irq_i  (irq_i),
        .wb_i   (wb_i),
        .wb_o   (wb_o),
        .meip_o (meip)
    );

endmodule

//--- tests/tb_csr_subsys.sv
`timescale 1ns/1ps

module tb_csr_subsys;

    logic               clk;
    logic               rst;
    logic               instr_valid_i;
    csr_pkg::xlen_t     instr_i;
    csr_pkg::addr_t     pc_i;
    csr_pkg::xlen_t     rs1_data_i;
    csr_pkg::irq_vec_t  irq_i;
    csr_pkg::wb_req_t   wb_i;
    csr_pkg::wb_rsp_t   wb_o;
    csr_pkg::xlen_t     rd_data_o;
    logic               trap_o;
    csr_pkg::addr_t     trap_pc_o;
    logic               mret_o;
    csr_pkg::addr_t     ret_pc_o;
    logic               stall_o;

    // request under issue, as the model sees it.
    logic               m_valid;
    csr_pkg::csr_op_e   m_op;
    csr_pkg::csr_addr_t m_addr;
    csr_pkg::xlen_t     m_operand;
    logic               m_nz;
    csr_pkg::addr_t     m_pc;

    // shadow machine state.
    logic               m_mie, m_mpie, m_meie, m_stall, m_ack, m_meip;
    csr_pkg::addr_t     m_mtvec, m_mepc;
    logic [63:0]        m_cycle, m_instret;
    csr_pkg::irq_vec_t  m_irq_q, m_pend, m_en;
    csr_pkg::xlen_t     m_rdat, m_old, m_new, exp_rd;
    logic               m_ok, m_trap, m_csr, m_write, m_mret, m_access;

    csr_pkg::addr_t     next_pc;
    csr_pkg::addr_t     issued_pc;
    logic               last_trap;

    csr_subsys csr_subsys_i (.*);

    always #50 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] expected);
        $display("** Error at %0t: %s got %0h expected %0h", $time, name, got, expected);
        $display("Simulation failed");
        $fatal(1, "value mismatch on %s", name);
    endtask

    task automatic report_failure(input string what);
        $display("** Error at %0t: %s", $time, what);
        $display("Simulation failed");
        $fatal(1, "%s", what);
    endtask

    function automatic csr_pkg::xlen_t csr_value(input csr_pkg::csr_addr_t addr);
        case (addr)
            csr_pkg::CSR_MSTATUS:   return {24'b0, m_mpie, 3'b0, m_mie, 3'b0};
            csr_pkg::CSR_MIE:       return {20'b0, m_meie, 11'b0};
            csr_pkg::CSR_MIP:       return {20'b0, m_meip, 11'b0};
            csr_pkg::CSR_MTVEC:     return m_mtvec;
            csr_pkg::CSR_MEPC:      return m_mepc;
            csr_pkg::CSR_MCYCLE:    return m_cycle[31:0];
            csr_pkg::CSR_MCYCLEH:   return m_cycle[63:32];
            csr_pkg::CSR_MINSTRET:  return m_instret[31:0];
            csr_pkg::CSR_MINSTRETH: return m_instret[63:32];
            default:                return '0;
        endcase
    endfunction

    always_comb begin
        m_ok    = m_valid && !m_stall;
        m_trap  = m_ok && m_meip && m_meie && m_mie;
        m_csr   = m_ok && !m_trap &&
                  (m_op inside {csr_pkg::WRITE, csr_pkg::SET, csr_pkg::CLEAR});
        m_mret  = m_ok && !m_trap && (m_op == csr_pkg::MRET);
        m_write = m_csr && ((m_op == csr_pkg::WRITE) || m_nz);
        m_old   = csr_value(m_addr);
        case (m_op)
            csr_pkg::SET:   m_new = m_old | m_operand;
            csr_pkg::CLEAR: m_new = m_old & ~m_operand;
            default:        m_new = m_operand;
        endcase
        exp_rd   = m_csr ? m_old : '0;
        m_access = wb_i.cyc && wb_i.stb && !m_ack;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            m_mie     <= 1'b0;
            m_mpie    <= 1'b0;
            m_meie    <= 1'b0;
            m_mtvec   <= csr_pkg::MTVEC_RESET;
            m_mepc    <= '0;
            m_stall   <= 1'b0;
            m_cycle   <= '0;
            m_instret <= '0;
            m_irq_q   <= '0;
            m_pend    <= '0;
            m_en      <= '0;
            m_ack     <= 1'b0;
            m_meip    <= 1'b0;
            m_rdat    <= '0;
        end
        else begin
            m_cycle <= m_cycle + 64'd1;
            if (m_ok && !m_trap) begin
                m_instret <= m_instret + 64'd1;
            end
            if (m_trap) begin
                m_mepc <= {m_pc[31:2], 2'b00};
                m_mpie <= m_mie;
                m_mie  <= 1'b0;
            end
            else if (m_ok && (m_op == csr_pkg::WFI)) begin
                m_mepc <= m_pc + 32'd4;
            end
            else if (m_mret) begin
                m_mie  <= m_mpie;
                m_mpie <= 1'b1;
            end
            else if (m_write) begin
                case (m_addr)
                    csr_pkg::CSR_MSTATUS: begin
                        m_mie  <= m_new[3];
                        m_mpie <= m_new[7];
                    end
                    csr_pkg::CSR_MIE:   m_meie  <= m_new[11];
                    csr_pkg::CSR_MTVEC: m_mtvec <= {m_new[31:2], 2'b00};
                    csr_pkg::CSR_MEPC:  m_mepc  <= {m_new[31:2], 2'b00};
                    default:            m_meie  <= m_meie;
                endcase
            end
            // wfi sleeps until meip, enables do not matter.
            if (m_ok && !m_trap && (m_op == csr_pkg::WFI)) begin
                m_stall <= !m_meip;
            end
            else if (m_meip) begin
                m_stall <= 1'b0;
            end
            m_irq_q <= irq_i;
            if (m_access && wb_i.we && (wb_i.adr == csr_pkg::IRQ_PENDING)) begin
                m_pend <= (m_pend & ~wb_i.dat[7:0]) | (irq_i & ~m_irq_q);
            end
            else begin
                m_pend <= m_pend | (irq_i & ~m_irq_q);
            end
            if (m_access && wb_i.we && (wb_i.adr == csr_pkg::IRQ_ENABLE)) begin
                m_en <= wb_i.dat[7:0];
            end
            if (m_access && !wb_i.we) begin
                case (wb_i.adr)
                    csr_pkg::IRQ_PENDING: m_rdat <= {24'b0, m_pend};
                    csr_pkg::IRQ_ENABLE:  m_rdat <= {24'b0, m_en};
                    csr_pkg::IRQ_RAW:     m_rdat <= {24'b0, irq_i};
                    default:              m_rdat <= '0;
                endcase
            end
            m_ack  <= m_access;
            m_meip <= |(m_pend & m_en);
        end
    end

    rd_match: assert property (@(posedge clk) disable iff (rst) rd_data_o == exp_rd)
        else report_mismatch("rd_data_o", $sampled(rd_data_o), $sampled(exp_rd));
    trap_match: assert property (@(posedge clk) disable iff (rst) trap_o == m_trap)
        else report_mismatch("trap_o", $sampled(trap_o), $sampled(m_trap));
    trap_pc_match: assert property (@(posedge clk) disable iff (rst)
        trap_o |-> trap_pc_o == m_mtvec)
        else report_mismatch("trap_pc_o", $sampled(trap_pc_o), $sampled(m_mtvec));
    mret_match: assert property (@(posedge clk) disable iff (rst) mret_o == m_mret)
        else report_mismatch("mret_o", $sampled(mret_o), $sampled(m_mret));
    ret_pc_match: assert property (@(posedge clk) disable iff (rst)
        mret_o |-> ret_pc_o == m_mepc)
        else report_mismatch("ret_pc_o", $sampled(ret_pc_o), $sampled(m_mepc));
    stall_match: assert property (@(posedge clk) disable iff (rst) stall_o == m_stall)
        else report_mismatch("stall_o", $sampled(stall_o), $sampled(m_stall));
    ack_match: assert property (@(posedge clk) disable iff (rst) wb_o.ack == m_ack)
        else report_mismatch("wb_o.ack", $sampled(wb_o.ack), $sampled(m_ack));
    wb_dat_match: assert property (@(posedge clk) disable iff (rst)
        (wb_o.ack && !wb_i.we) |-> wb_o.dat == m_rdat)
        else report_mismatch("wb_o.dat", $sampled(wb_o.dat), $sampled(m_rdat));

    task automatic issue_word(input csr_pkg::xlen_t instr, input csr_pkg::xlen_t rs1,
                              input csr_pkg::csr_op_e op, input csr_pkg::csr_addr_t addr,
                              input csr_pkg::xlen_t operand, input logic nz,
                              output csr_pkg::xlen_t rd);
        int n;
        n = 0;
        while (stall_o) begin
            if (n == 50) report_failure("timeout waiting for stall_o to fall before issue");
            n++;
            @(posedge clk);
            #5;
        end
        issued_pc     = next_pc;
        next_pc       = next_pc + 32'd4;
        instr_valid_i = 1'b1;
        instr_i       = instr;
        pc_i          = issued_pc;
        rs1_data_i    = rs1;
        m_valid       = 1'b1;
        m_op          = op;
        m_addr        = addr;
        m_operand     = operand;
        m_nz          = nz;
        m_pc          = issued_pc;
        @(negedge clk);
        rd        = rd_data_o;
        last_trap = trap_o;
        @(posedge clk);
        #5;
        instr_valid_i = 1'b0;
        m_valid       = 1'b0;
    endtask

    task automatic issue_csr(input csr_pkg::csr_op_e op, input logic imm,
                             input csr_pkg::csr_addr_t addr, input logic [4:0] src,
                             input csr_pkg::xlen_t rs1, output csr_pkg::xlen_t rd);
        logic [2:0]     funct3;
        csr_pkg::xlen_t instr;
        funct3 = {imm, (op == csr_pkg::SET) || (op == csr_pkg::CLEAR),
                  (op == csr_pkg::WRITE) || (op == csr_pkg::CLEAR)};
        instr  = {addr, src, funct3, 5'd1, 7'b1110011};
        issue_word(instr, rs1, op, addr, imm ? {27'b0, src} : rs1, src != 5'd0, rd);
    endtask

    task automatic read_csr(input csr_pkg::csr_addr_t addr, output csr_pkg::xlen_t rd);
        issue_csr(csr_pkg::SET, 1'b0, addr, 5'd0, '0, rd);
    endtask

    task automatic wait_meip(input logic level);
        csr_pkg::xlen_t v;
        int n;
        n = 0;
        read_csr(csr_pkg::CSR_MIP, v);
        while (v[11] != level) begin
            if (n == 50) report_failure("timeout waiting for mip.MEIP to change");
            n++;
            read_csr(csr_pkg::CSR_MIP, v);
        end
    endtask

    task automatic wb_access(input logic we, input csr_pkg::wb_adr_t adr,
                             input csr_pkg::xlen_t dat, output csr_pkg::xlen_t rdat);
        int n;
        n = 0;
        wb_i = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        @(posedge clk);
        #5;
        while (!wb_o.ack) begin
            if (n == 50) report_failure("timeout waiting for wishbone ack");
            n++;
            @(posedge clk);
            #5;
        end
        rdat = wb_o.dat;
        wb_i = '0;
        @(posedge clk);
        #5;
    endtask

    csr_pkg::csr_addr_t all_csrs[9] = '{csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MIE,
        csr_pkg::CSR_MTVEC, csr_pkg::CSR_MEPC, csr_pkg::CSR_MIP, csr_pkg::CSR_MCYCLE,
        csr_pkg::CSR_MCYCLEH, csr_pkg::CSR_MINSTRET, csr_pkg::CSR_MINSTRETH};
    csr_pkg::csr_addr_t rw_csrs[4] = '{csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MIE,
        csr_pkg::CSR_MTVEC, csr_pkg::CSR_MEPC};

    initial begin
        csr_pkg::xlen_t   rd;
        csr_pkg::xlen_t   first;
        csr_pkg::xlen_t   second;
        csr_pkg::addr_t   saved_pc;
        csr_pkg::csr_op_e op;
        int               n;
        void'($urandom(32'hf368));
        clk = 1'b0;
        rst = 1'b1;
        instr_valid_i = 1'b0;
        instr_i = '0;
        pc_i = '0;
        rs1_data_i = '0;
        irq_i = '0;
        wb_i = '0;
        m_valid = 1'b0;
        m_op = csr_pkg::NONE;
        m_addr = '0;
        m_operand = '0;
        m_nz = 1'b0;
        m_pc = '0;
        next_pc = 32'h0000_1000;
        repeat (16) @(posedge clk);
        #5;
        rst = 1'b0;

        foreach (all_csrs[i]) read_csr(all_csrs[i], rd);

        // random read-modify-write traffic.
        for (int i = 0; i < 48; i++) begin
            case ($urandom_range(0, 2))
                0:       op = csr_pkg::WRITE;
                1:       op = csr_pkg::SET;
                default: op = csr_pkg::CLEAR;
            endcase
            n = ($urandom_range(0, 3) == 0) ? 0 : $urandom_range(1, 31);
            issue_csr(op, 1'($urandom_range(0, 1)), rw_csrs[$urandom_range(0, 3)],
                      5'(n), $urandom(), rd);
        end

        n = $urandom_range(1, 10);
        read_csr(csr_pkg::CSR_MCYCLE, first);
        repeat (n) @(posedge clk);
        #5;
        read_csr(csr_pkg::CSR_MCYCLE, second);
        assert (second - first == 32'(n + 1))
            else report_mismatch("mcycle delta", second - first, 64'(n + 1));
        n = $urandom_range(2, 8);
        read_csr(csr_pkg::CSR_MINSTRET, first);
        repeat (n) read_csr(csr_pkg::CSR_MSTATUS, rd);
        read_csr(csr_pkg::CSR_MINSTRET, second);
        assert (second - first == 32'(n + 1))
            else report_mismatch("minstret delta", second - first, 64'(n + 1));

        // external interrupt trap and return.
        wb_access(1'b1, csr_pkg::IRQ_ENABLE, 32'h03, rd);
        wb_access(1'b0, csr_pkg::IRQ_ENABLE, '0, rd);
        issue_csr(csr_pkg::WRITE, 1'b0, csr_pkg::CSR_MIE, 5'd5, 32'h800, rd);
        issue_csr(csr_pkg::CLEAR, 1'b1, csr_pkg::CSR_MSTATUS, 5'd8, '0, rd);
        irq_i[0] = 1'b1;
        wait_meip(1'b1);
        issue_csr(csr_pkg::SET, 1'b1, csr_pkg::CSR_MSTATUS, 5'd8, '0, rd);
        read_csr(csr_pkg::CSR_MTVEC, rd);
        assert (last_trap) else report_failure("pending interrupt did not trap");
        saved_pc = issued_pc;
        read_csr(csr_pkg::CSR_MEPC, rd);
        assert (rd == saved_pc) else report_mismatch("mepc", rd, saved_pc);
        read_csr(csr_pkg::CSR_MSTATUS, rd);
        assert (!rd[3]) else report_failure("mstatus.MIE still set after trap");
        wb_access(1'b1, csr_pkg::IRQ_PENDING, 32'h01, rd);
        wait_meip(1'b0);
        issue_word(32'h3020_0073, '0, csr_pkg::MRET, 12'h302, '0, 1'b0, rd);
        read_csr(csr_pkg::CSR_MSTATUS, rd);
        assert (rd[3]) else report_failure("mstatus.MIE not restored by mret");

        // wfi sleep and wake.
        issue_csr(csr_pkg::CLEAR, 1'b1, csr_pkg::CSR_MSTATUS, 5'd8, '0, rd);
        issue_word(32'h1050_0073, '0, csr_pkg::WFI, 12'h105, '0, 1'b0, rd);
        saved_pc = issued_pc;
        repeat ($urandom_range(3, 20)) begin
            assert (stall_o) else report_failure("stall_o fell with no interrupt");
            @(posedge clk);
            #5;
        end
        irq_i[1] = 1'b1;
        n = 0;
        while (stall_o) begin
            if (n == 50) report_failure("timeout waiting for wfi wake");
            n++;
            @(posedge clk);
            #5;
        end
        read_csr(csr_pkg::CSR_MEPC, rd);
        assert (rd == saved_pc + 32'd4) else report_mismatch("mepc", rd, saved_pc + 32'd4);

        irq_i = 8'($urandom());
        wb_access(1'b0, csr_pkg::IRQ_RAW, '0, rd);
        assert (rd == {24'b0, irq_i}) else report_mismatch("IRQ_RAW", rd, irq_i);
        wb_access(1'b1, csr_pkg::IRQ_PENDING, 32'hff, rd);

        $display("Simulation passed");
        $finish;
    end

endmodule

//--- list.f
hw/csr_pkg.sv
hw/csr_decode.sv
hw/csr_file.sv
hw/ext_irq_ctrl.sv
hw/csr_subsys.sv
tests/tb_csr_subsys.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_csr_subsys \
    -f list.f \
    -o tb_csr_subsys

./obj_dir/tb_csr_subsys
